// ==== daq_core.f ====
+incdir+include
src/daq_pkg.sv
src/pulse_gen.sv
src/daq_regs.sv
src/event_capture.sv
src/word_fifo.sv
src/rr_arbiter.sv
src/daq_core.sv
dv/daq_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the daq_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module daq_core_tb \
    -f daq_core.f \
    -o daq_core_sim

./obj_dir/daq_core_sim | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== dv/daq_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "daq_consts.svh"

module daq_core_tb import daq_pkg::*; ();

    localparam time CLK_PERIOD  = 40;
    localparam int  SEED        = 1338;
    localparam int  DRAIN_LIMIT = 300;
    // Test lengths in clock cycles
    localparam int  T_RESET  = 20;
    localparam int  T_SYS    = 60;
    localparam int  T_CTRL   = 80;
    localparam int  T_PULSE  = 200;
    localparam int  T_EVENT  = 200;
    localparam int  T_BURSTS = 600;
    localparam int  T_MARGIN = 500;
    localparam int  RUN_CYCLES = T_RESET + T_SYS + T_CTRL + T_PULSE + T_EVENT + T_BURSTS
                               + T_MARGIN;

    localparam bus_addr_t SYS   = `DAQ_SYS_BASE;
    localparam bus_addr_t PULSE = `DAQ_PULSE_BASE;
    localparam bus_addr_t CTRL  = `DAQ_CTRL_BASE;

    logic       BUS_CLK;
    logic       BUS_RST;
    bus_addr_t  bus_add;
    bus_data_t  bus_wdata;
    logic       bus_rd;
    logic       bus_wr;
    logic [3:0] gpio_sense;
    logic       reset_req;
    logic       trigger;
    logic       hitor;
    logic       arb_ready;
    bus_data_t  bus_rdata;
    logic       mgt_ref_sel;
    logic [7:0] lemo_mux;
    logic [2:0] ntc_mux;
    logic       resetb_ext;
    logic       arb_write;
    data_word_t arb_data;

    // Register model of the bus side
    logic        model_flag  = 1'b0;
    logic [15:0] model_ctrl  = '0;
    logic [3:0]  sense_v     = '0;
    logic [7:0]  model_delay = '0;
    logic [7:0]  model_width = '0;
    logic        model_done  = 1'b0;

    // Stream bookkeeping
    int          trig_sent   = 0;
    int          trig_seen   = 0;
    int          hit_sent    = 0;
    int          hit_seen    = 0;
    logic [15:0] hit_ts_q[$];
    logic [15:0] last_ts     = '0;
    hit_word_t   hit_got;
    time         t_rel;
    bit          bp_on       = 1'b0;
    int          err_count   = 0;
    int          fault_count = 0;

    daq_core DUT (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_bus_add     (bus_add),
        .i_bus_data    (bus_wdata),
        .i_bus_rd      (bus_rd),
        .i_bus_wr      (bus_wr),
        .i_gpio_sense  (gpio_sense),
        .i_reset_req   (reset_req),
        .i_trigger     (trigger),
        .i_hitor       (hitor),
        .i_arb_ready   (arb_ready),
        .o_bus_data    (bus_rdata),
        .o_mgt_ref_sel (mgt_ref_sel),
        .o_lemo_mux    (lemo_mux),
        .o_ntc_mux     (ntc_mux),
        .o_resetb_ext  (resetb_ext),
        .o_arb_write   (arb_write),
        .o_arb_data    (arb_data)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    function automatic bus_addr_t win_addr(input bus_addr_t base, input logic [7:0] off);
        return {base[15:8], off};
    endfunction

    // Expected read byte for any bus address
    function automatic bus_data_t exp_reg(input bus_addr_t a);
        bus_data_t r;
        r = '0;
        if (a[15:8] == SYS[15:8]) begin
            case (a[7:0])
                `DAQ_SYS_VERSION: r = `DAQ_VERSION;
                `DAQ_SYS_MINOR:   r = `DAQ_FW_MINOR;
                `DAQ_SYS_MAJOR:   r = `DAQ_FW_MAJOR;
                `DAQ_SYS_BOARD:   r = `DAQ_BOARD_ID;
                `DAQ_SYS_FLAG_RD: r = {7'd0, model_flag};
                default:          r = '0;
            endcase
        end else if (a[15:8] == PULSE[15:8]) begin
            case (a[7:0])
                `DAQ_PULSE_DELAY: r = model_delay;
                `DAQ_PULSE_WIDTH: r = model_width;
                `DAQ_PULSE_DONE:  r = {7'd0, model_done};
                default:          r = '0;
            endcase
        end else if (a[15:8] == CTRL[15:8]) begin
            case (a[7:0])
                `DAQ_CTRL_LO: r = {model_ctrl[7:4], sense_v};
                `DAQ_CTRL_HI: r = model_ctrl[15:8];
                default:      r = '0;
            endcase
        end
        return r;
    endfunction

    // {ref clock select, LEMO mux, NTC mux}
    function automatic logic [11:0] exp_ctrl_out(input logic [15:0] c);
        return {~c[15], c[14:7], c[6:4]};
    endfunction

    // Cycle offset from the start cycle
    function automatic bit pulse_active(input int rel, input int d, input int w);
        return (rel >= d + 1) && (rel <= d + w);
    endfunction

    function automatic trig_word_t exp_trig(input int n);
        trig_word_t t;
        t.marker = 1'b1;
        t.number = 31'(n);
        return t;
    endfunction

    function automatic logic [11:0] exp_hit_count(input int n);
        return 12'(n);
    endfunction

    function automatic hit_word_t exp_hit(input int n, input logic [15:0] ts);
        hit_word_t h;
        h.marker    = 1'b0;
        h.id        = 3'd2;
        h.count     = exp_hit_count(n);
        h.timestamp = ts;
        return h;
    endfunction

    // Timestamp seen by the edge detector after the synchronizer
    function automatic logic [15:0] exp_hit_ts(input time t_edge);
        return 16'((t_edge - t_rel) / CLK_PERIOD + `DAQ_SYNC_STAGES);
    endfunction

    task automatic check_byte(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_trig(input string name, input trig_word_t exp, input trig_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_hit(input string name, input hit_word_t exp, input hit_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic note_fault(input string what);
        $display("ERROR: %s", what);
        fault_count++;
    endtask

    task automatic bus_write(input bus_addr_t a, input bus_data_t d);
        @(posedge BUS_CLK);
        bus_add   <= a;
        bus_wdata <= d;
        bus_wr    <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_data_t d);
        @(posedge BUS_CLK);
        bus_add <= a;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        d = bus_rdata;
    endtask

    task automatic read_check(input string name, input bus_addr_t a);
        bus_data_t got;
        bus_read(a, got);
        check_byte(name, exp_reg(a), got);
    endtask

    task automatic check_ctrl_outputs(input string name);
        logic [11:0] e;
        e = exp_ctrl_out(model_ctrl);
        check_level(name, e[11], mgt_ref_sel);
        check_byte(name, e[10:3], lemo_mux);
        check_byte(name, {5'd0, e[2:0]}, {5'd0, ntc_mux});
    endtask

    task automatic ctrl_case();
        bus_data_t lo;
        bus_data_t hi;
        lo      = 8'($urandom);
        hi      = 8'($urandom);
        sense_v = 4'($urandom);
        @(posedge BUS_CLK);
        gpio_sense <= sense_v;
        bus_write(win_addr(CTRL, `DAQ_CTRL_LO), lo);
        bus_write(win_addr(CTRL, `DAQ_CTRL_HI), hi);
        model_ctrl = {hi, lo[7:4], 4'h0};
        @(negedge BUS_CLK);
        check_ctrl_outputs("ctrl_outputs");
        read_check("ctrl_low_byte", win_addr(CTRL, `DAQ_CTRL_LO));
        read_check("ctrl_high_byte", win_addr(CTRL, `DAQ_CTRL_HI));
    endtask

    // Start the pulser and follow o_resetb_ext cycle by cycle
    task automatic run_pulse(input string name, input bit ext, input int d, input int w);
        int offset;
        int again;
        int last;
        offset = ext ? `DAQ_SYNC_STAGES : 0;
        again  = (w > 0) ? offset + 1 + (d + w - 1) / 2 : -1;
        last   = offset + d + w + 3;
        @(posedge BUS_CLK);
        if (ext) begin
            reset_req <= 1'b1;
        end else begin
            bus_add <= win_addr(PULSE, `DAQ_PULSE_START);
            bus_wr  <= 1'b1;
        end
        for (int k = 0; k <= last; k++) begin
            @(negedge BUS_CLK);
            check_level(name, !pulse_active(k - offset, d, w), resetb_ext);
            @(posedge BUS_CLK);
            bus_wr <= 1'b0;
            // Second start lands while the first is still busy
            if (k + 1 == again) begin
                bus_add <= win_addr(PULSE, `DAQ_PULSE_START);
                bus_wr  <= 1'b1;
            end
        end
        reset_req <= 1'b0;
        if (w > 0)
            model_done = 1'b1;
    endtask

    task automatic random_pulse(input string name, input bit ext);
        int d;
        int w;
        d = $urandom % 16;
        w = 1 + $urandom % 15;
        bus_write(win_addr(PULSE, `DAQ_PULSE_DELAY), 8'(d));
        bus_write(win_addr(PULSE, `DAQ_PULSE_WIDTH), 8'(w));
        model_delay = 8'(d);
        model_width = 8'(w);
        read_check("pulse_delay", win_addr(PULSE, `DAQ_PULSE_DELAY));
        read_check("pulse_width", win_addr(PULSE, `DAQ_PULSE_WIDTH));
        run_pulse(name, ext, d, w);
        read_check("pulse_done", win_addr(PULSE, `DAQ_PULSE_DONE));
    endtask

    task automatic send_trig_edges(input int n);
        int high;
        int low;
        repeat (n) begin
            high = 1 + $urandom % 3;
            low  = 2 + $urandom % 3;
            @(posedge BUS_CLK);
            trigger <= 1'b1;
            trig_sent++;
            repeat (high) @(posedge BUS_CLK);
            trigger <= 1'b0;
            repeat (low - 1) @(posedge BUS_CLK);
        end
    endtask

    task automatic send_hit_edges(input int n);
        int high;
        int low;
        repeat (n) begin
            high = 1 + $urandom % 3;
            low  = 2 + $urandom % 3;
            @(posedge BUS_CLK);
            hitor <= 1'b1;
            hit_ts_q.push_back(exp_hit_ts($time));
            hit_sent++;
            repeat (high) @(posedge BUS_CLK);
            hitor <= 1'b0;
            repeat (low - 1) @(posedge BUS_CLK);
        end
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while ((trig_seen != trig_sent || hit_seen != hit_sent) && n < DRAIN_LIMIT) begin
            @(posedge BUS_CLK);
            n++;
        end
        if (trig_seen != trig_sent || hit_seen != hit_sent)
            note_fault($sformatf("%s: stream words still missing after %0d cycles",
                                 name, DRAIN_LIMIT));
    endtask

    task automatic edge_burst(input string name, input int max_n);
        int n_trig;
        int n_hit;
        n_trig = 1 + $urandom % max_n;
        n_hit  = 1 + $urandom % max_n;
        fork
            send_trig_edges(n_trig);
            send_hit_edges(n_hit);
        join
        wait_drain(name);
    endtask

    // Compares every stream word against the expected sequence per source
    always @(negedge BUS_CLK) begin
        if (!BUS_RST && arb_write) begin
            if (!arb_ready)
                note_fault("stream word written while ready was low");
            if (arb_data[31]) begin
                if (trig_seen >= trig_sent)
                    note_fault("trigger word arrived that was never sent");
                check_trig("stream_trigger", exp_trig(trig_seen), trig_word_t'(arb_data));
                trig_seen++;
            end else if (hit_ts_q.size() == 0) begin
                note_fault("hit word arrived that was never sent");
            end else begin
                hit_got = hit_word_t'(arb_data);
                check_hit("stream_hit", exp_hit(hit_seen, hit_ts_q.pop_front()), hit_got);
                if (hit_seen > 0)
                    check_level("hit_timestamp_rising", 1'b1, hit_got.timestamp > last_ts);
                last_ts = hit_got.timestamp;
                hit_seen++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * RUN_CYCLES);
        $display("Watchdog expired after %0d cycles before the tests finished", RUN_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        BUS_RST    <= 1'b1;
        bus_add    <= '0;
        bus_wdata  <= '0;
        bus_rd     <= 1'b0;
        bus_wr     <= 1'b0;
        gpio_sense <= '0;
        reset_req  <= 1'b0;
        trigger    <= 1'b0;
        hitor      <= 1'b0;
        arb_ready  <= 1'b1;
        repeat (10) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;
        t_rel = $time;

        @(negedge BUS_CLK);
        check_byte("reset_bus_data", 8'h00, bus_rdata);
        check_ctrl_outputs("reset_ctrl");
        check_level("reset_resetb", 1'b1, resetb_ext);
        check_level("reset_arb_write", 1'b0, arb_write);

        read_check("sys_version", win_addr(SYS, `DAQ_SYS_VERSION));
        read_check("sys_minor", win_addr(SYS, `DAQ_SYS_MINOR));
        read_check("sys_major", win_addr(SYS, `DAQ_SYS_MAJOR));
        read_check("sys_board", win_addr(SYS, `DAQ_SYS_BOARD));
        read_check("sys_flag_clear", win_addr(SYS, `DAQ_SYS_FLAG_RD));
        bus_write(win_addr(SYS, `DAQ_SYS_FLAG_WR), 8'h01);
        model_flag = 1'b1;
        read_check("sys_flag_set", win_addr(SYS, `DAQ_SYS_FLAG_RD));
        read_check("sys_write_only", win_addr(SYS, `DAQ_SYS_FLAG_WR));
        read_check("sys_unmapped", win_addr(SYS, 8'h06));
        read_check("pulse_unmapped", win_addr(PULSE, 8'h04));
        read_check("ctrl_unmapped", win_addr(CTRL, 8'h02));
        read_check("outside_windows", 16'h0600);

        repeat (4) ctrl_case();

        // Zero width gives no pulse at all
        run_pulse("pulse_zero_width", 1'b0, 0, 0);
        random_pulse("pulse_bus_start", 1'b0);
        random_pulse("pulse_ext_start", 1'b1);

        edge_burst("events", 12);

        bp_on = 1'b1;
        fork
            while (bp_on) begin
                @(posedge BUS_CLK);
                arb_ready <= bp_on ? 1'($urandom % 2) : 1'b1;
            end
        join_none
        repeat (4) edge_burst("backpressure", `DAQ_FIFO_DEPTH);
        bp_on = 1'b0;
        repeat (5) @(posedge BUS_CLK);
        if (trig_seen != trig_sent || hit_seen != hit_sent)
            note_fault("stream word count differs from the number of edges sent");

        $display("Summary: %0d value mismatches, %0d other errors", err_count, fault_count);
        if (err_count == 0 && fault_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/daq_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module daq_core import daq_pkg::*; (
    input  wire        BUS_CLK,
    input  wire        BUS_RST,
    input  bus_addr_t  i_bus_add,
    input  bus_data_t  i_bus_data,
    input  wire        i_bus_rd,
    input  wire        i_bus_wr,
    input  wire  [3:0] i_gpio_sense,
    input  wire        i_reset_req,
    input  wire        i_trigger,
    input  wire        i_hitor,
    input  wire        i_arb_ready,
    output bus_data_t  o_bus_data,
    output wire        o_mgt_ref_sel,
    output wire  [7:0] o_lemo_mux,
    output wire  [2:0] o_ntc_mux,
    output wire        o_resetb_ext,
    output wire        o_arb_write,
    output data_word_t o_arb_data
);

    wire        trig_wr;
    trig_word_t trig_word;
    wire        hit_wr;
    hit_word_t  hit_word;
    trig_word_t trig_head;
    hit_word_t  hit_head;
    wire        trig_empty;
    wire        hit_empty;
    wire  [1:0] grant;

    daq_regs u_regs (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .i_bus_add     (i_bus_add),
        .i_bus_data    (i_bus_data),
        .i_bus_rd      (i_bus_rd),
        .i_bus_wr      (i_bus_wr),
        .i_gpio_sense  (i_gpio_sense),
        .i_reset_req   (i_reset_req),
        .o_bus_data    (o_bus_data),
        .o_mgt_ref_sel (o_mgt_ref_sel),
        .o_lemo_mux    (o_lemo_mux),
        .o_ntc_mux     (o_ntc_mux),
        .o_resetb_ext  (o_resetb_ext)
    );

    event_capture u_capture (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_trigger   (i_trigger),
        .i_hitor     (i_hitor),
        .o_trig_wr   (trig_wr),
        .o_trig_word (trig_word),
        .o_hit_wr    (hit_wr),
        .o_hit_word  (hit_word)
    );

    word_fifo #(.payload_t(trig_word_t)) u_trig_fifo (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .i_wr    (trig_wr),
        .i_data  (trig_word),
        .i_rd    (grant[0]),
        .o_data  (trig_head),
        .o_empty (trig_empty),
        .o_full  ()
    );

    word_fifo #(.payload_t(hit_word_t)) u_hit_fifo (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .i_wr    (hit_wr),
        .i_data  (hit_word),
        .i_rd    (grant[1]),
        .o_data  (hit_head),
        .o_empty (hit_empty),
        .o_full  ()
    );

    // Trigger FIFO on requester a, hit FIFO on b
    rr_arbiter u_arbiter (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .i_req    ({~hit_empty, ~trig_empty}),
        .i_data_a (trig_head),
        .i_data_b (hit_head),
        .i_ready  (i_arb_ready),
        .o_grant  (grant),
        .o_write  (o_arb_write),
        .o_data   (o_arb_data)
    );

endmodule

`default_nettype wire

// ==== src/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter import daq_pkg::*; (
    input  wire        BUS_CLK,
    input  wire        BUS_RST,
    input  wire  [1:0] i_req,
    input  data_word_t i_data_a,
    input  data_word_t i_data_b,
    input  wire        i_ready,
    output logic [1:0] o_grant,
    output logic       o_write,
    output data_word_t o_data
);

    // Requester served last, 0 for a and 1 for b
    logic last_b;

    always_comb begin
        o_grant = 2'b00;
        if (i_ready) begin
            case (i_req)
                2'b01:   o_grant = 2'b01;
                2'b10:   o_grant = 2'b10;
                2'b11:   o_grant = last_b ? 2'b01 : 2'b10;
                default: o_grant = 2'b00;
            endcase
        end
    end

    assign o_write = |o_grant;
    assign o_data  = o_grant[1] ? i_data_b : i_data_a;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            last_b <= 1'b0;
        else if (o_write)
            last_b <= o_grant[1];
    end

endmodule

`default_nettype wire

// ==== src/word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "daq_consts.svh"

module word_fifo import daq_pkg::*; #(
    parameter type payload_t = data_word_t
) (
    input  wire      BUS_CLK,
    input  wire      BUS_RST,
    input  wire      i_wr,
    input  payload_t i_data,
    input  wire      i_rd,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);

    localparam int AW = $clog2(`DAQ_FIFO_DEPTH);

    payload_t      mem [`DAQ_FIFO_DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;

    // Extra pointer bit tells full from empty
    assign o_empty = wr_ptr == rd_ptr;
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Head word is visible without a read
    assign o_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (i_wr && !o_full)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_rd && !o_empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (i_wr && !o_full)
            mem[wr_ptr[AW-1:0]] <= i_data;
    end

endmodule

`default_nettype wire

// ==== src/event_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "daq_consts.svh"

module event_capture import daq_pkg::*; (
    input  wire        BUS_CLK,
    input  wire        BUS_RST,
    input  wire        i_trigger,
    input  wire        i_hitor,
    output logic       o_trig_wr,
    output trig_word_t o_trig_word,
    output logic       o_hit_wr,
    output hit_word_t  o_hit_word
);

    logic [`DAQ_SYNC_STAGES-1:0] trig_sync;
    logic [`DAQ_SYNC_STAGES-1:0] hit_sync;
    logic                        trig_last;
    logic                        hit_last;
    logic                        trig_rise;
    logic                        hit_rise;
    logic [15:0]                 timestamp;
    logic [30:0]                 trig_cnt;
    logic [11:0]                 hit_cnt;

    assign trig_rise = trig_sync[`DAQ_SYNC_STAGES-1] & ~trig_last;
    assign hit_rise  = hit_sync[`DAQ_SYNC_STAGES-1] & ~hit_last;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            trig_sync <= '0;
            hit_sync  <= '0;
            trig_last <= 1'b0;
            hit_last  <= 1'b0;
            timestamp <= '0;
            trig_cnt  <= '0;
            hit_cnt   <= '0;
            o_trig_wr <= 1'b0;
            o_hit_wr  <= 1'b0;
        end else begin
            trig_sync <= {trig_sync[`DAQ_SYNC_STAGES-2:0], i_trigger};
            hit_sync  <= {hit_sync[`DAQ_SYNC_STAGES-2:0], i_hitor};
            trig_last <= trig_sync[`DAQ_SYNC_STAGES-1];
            hit_last  <= hit_sync[`DAQ_SYNC_STAGES-1];
            timestamp <= timestamp + 16'd1;

            // Write strobe lines up with the word register below
            o_trig_wr <= trig_rise;
            o_hit_wr  <= hit_rise;
            if (trig_rise)
                trig_cnt <= trig_cnt + 31'd1;
            if (hit_rise)
                hit_cnt <= hit_cnt + 12'd1;
        end
    end

    // Word carries the count before the increment
    always_ff @(posedge BUS_CLK) begin
        if (trig_rise)
            o_trig_word <= '{marker: 1'b1, number: trig_cnt};
        if (hit_rise)
            o_hit_word <= '{marker: 1'b0,
                            id: `DAQ_HIT_ID,
                            count: hit_cnt,
                            timestamp: timestamp};
    end

endmodule

`default_nettype wire

// ==== src/daq_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "daq_consts.svh"

module daq_regs import daq_pkg::*; (
    input  wire        BUS_CLK,
    input  wire        BUS_RST,
    input  bus_addr_t  i_bus_add,
    input  bus_data_t  i_bus_data,
    input  wire        i_bus_rd,
    input  wire        i_bus_wr,
    input  wire  [3:0] i_gpio_sense,
    input  wire        i_reset_req,
    output bus_data_t  o_bus_data,
    output logic       o_mgt_ref_sel,
    output logic [7:0] o_lemo_mux,
    output logic [2:0] o_ntc_mux,
    output logic       o_resetb_ext
);

    logic                        in_sys;
    logic                        in_ctrl;
    logic [7:0]                  offset;
    logic                        clk_flag;
    logic [15:4]                 ctrl_q;
    logic [15:0]                 ctrl_word;
    logic [`DAQ_SYNC_STAGES-1:0] req_sync;
    logic                        pulse;
    bus_data_t                   pulse_rd;
    bus_data_t                   local_rd;

    assign in_sys  = (i_bus_add & `DAQ_WIN_MASK) == `DAQ_SYS_BASE;
    assign in_ctrl = (i_bus_add & `DAQ_WIN_MASK) == `DAQ_CTRL_BASE;
    assign offset  = i_bus_add[7:0];

    // Low nibble always shows the live sense lines
    assign ctrl_word = {ctrl_q, i_gpio_sense};

    // Register value 0 selects the internal reference clock
    assign o_mgt_ref_sel = ~ctrl_word[15];
    assign o_lemo_mux    = ctrl_word[14:7];
    assign o_ntc_mux     = ctrl_word[6:4];
    assign o_resetb_ext  = ~pulse;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            clk_flag <= 1'b0;
            ctrl_q   <= '0;
            req_sync <= '0;
        end else begin
            req_sync <= {req_sync[`DAQ_SYNC_STAGES-2:0], i_reset_req};
            if (i_bus_wr && in_sys && offset == `DAQ_SYS_FLAG_WR)
                clk_flag <= i_bus_data[0];
            if (i_bus_wr && in_ctrl && offset == `DAQ_CTRL_LO)
                ctrl_q[7:4] <= i_bus_data[7:4];
            if (i_bus_wr && in_ctrl && offset == `DAQ_CTRL_HI)
                ctrl_q[15:8] <= i_bus_data;
        end
    end

    always_comb begin
        local_rd = '0;
        if (in_sys) begin
            case (offset)
                `DAQ_SYS_VERSION: local_rd = `DAQ_VERSION;
                `DAQ_SYS_MINOR:   local_rd = `DAQ_FW_MINOR;
                `DAQ_SYS_MAJOR:   local_rd = `DAQ_FW_MAJOR;
                `DAQ_SYS_BOARD:   local_rd = `DAQ_BOARD_ID;
                `DAQ_SYS_FLAG_RD: local_rd = {7'd0, clk_flag};
                default:          local_rd = '0;
            endcase
        end else if (in_ctrl) begin
            case (offset)
                `DAQ_CTRL_LO: local_rd = ctrl_word[7:0];
                `DAQ_CTRL_HI: local_rd = ctrl_word[15:8];
                default:      local_rd = '0;
            endcase
        end
    end

    // Read byte holds until the next read strobe
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST)
            o_bus_data <= '0;
        else if (i_bus_rd)
            o_bus_data <= local_rd | pulse_rd;
    end

    pulse_gen u_pulse_rst (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_bus_add   (i_bus_add),
        .i_bus_data  (i_bus_data),
        .i_bus_rd    (i_bus_rd),
        .i_bus_wr    (i_bus_wr),
        .i_ext_start (req_sync[`DAQ_SYNC_STAGES-1]),
        .o_rd_data   (pulse_rd),
        .o_pulse     (pulse)
    );

endmodule

`default_nettype wire

// ==== src/pulse_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "daq_consts.svh"

module pulse_gen import daq_pkg::*; (
    input  wire       BUS_CLK,
    input  wire       BUS_RST,
    input  bus_addr_t i_bus_add,
    input  bus_data_t i_bus_data,
    input  wire       i_bus_rd,
    input  wire       i_bus_wr,
    input  wire       i_ext_start,
    output bus_data_t o_rd_data,
    output logic      o_pulse
);

    logic       in_win;
    logic [7:0] offset;
    logic [7:0] delay_q;
    logic [7:0] width_q;
    logic [7:0] dly_cnt;
    logic [7:0] wid_cnt;
    logic       pending;
    logic       done;
    logic       ext_q;
    logic       start_req;
    logic       start;

    assign in_win = (i_bus_add & `DAQ_WIN_MASK) == `DAQ_PULSE_BASE;
    assign offset = i_bus_add[7:0];

    // Either a bus write to the start offset or a rising external request
    assign start_req = (i_bus_wr && in_win && offset == `DAQ_PULSE_START)
                     || (i_ext_start && !ext_q);
    // Busy or zero width swallows the request
    assign start = start_req && !pending && !o_pulse && width_q != 8'd0;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            delay_q <= '0;
            width_q <= '0;
            dly_cnt <= '0;
            wid_cnt <= '0;
            pending <= 1'b0;
            o_pulse <= 1'b0;
            done    <= 1'b0;
            ext_q   <= 1'b0;
        end else begin
            ext_q <= i_ext_start;
            if (i_bus_wr && in_win && offset == `DAQ_PULSE_DELAY)
                delay_q <= i_bus_data;
            if (i_bus_wr && in_win && offset == `DAQ_PULSE_WIDTH)
                width_q <= i_bus_data;

            if (start) begin
                done    <= 1'b0;
                wid_cnt <= width_q - 8'd1;
                // Zero delay goes high on the very next cycle
                if (delay_q == 8'd0) begin
                    o_pulse <= 1'b1;
                end else begin
                    pending <= 1'b1;
                    dly_cnt <= delay_q - 8'd1;
                end
            end else if (pending) begin
                if (dly_cnt == 8'd0) begin
                    pending <= 1'b0;
                    o_pulse <= 1'b1;
                end else begin
                    dly_cnt <= dly_cnt - 8'd1;
                end
            end else if (o_pulse) begin
                if (wid_cnt == 8'd0) begin
                    o_pulse <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    wid_cnt <= wid_cnt - 8'd1;
                end
            end
        end
    end

    always_comb begin
        o_rd_data = '0;
        if (i_bus_rd && in_win) begin
            case (offset)
                `DAQ_PULSE_DELAY: o_rd_data = delay_q;
                `DAQ_PULSE_WIDTH: o_rd_data = width_q;
                `DAQ_PULSE_DONE:  o_rd_data = {7'd0, done};
                default:          o_rd_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/daq_pkg.sv ====
`default_nettype none

`include "daq_consts.svh"

package daq_pkg;

    typedef logic [`DAQ_ABUS_W-1:0] bus_addr_t;
    typedef logic [`DAQ_DBUS_W-1:0] bus_data_t;

    // Trigger word, marker always set
    typedef struct packed {
        logic        marker;
        logic [30:0] number;
    } trig_word_t;

    // Hit word, marker always clear
    typedef struct packed {
        logic        marker;
        logic [2:0]  id;
        logic [11:0] count;
        logic [15:0] timestamp;
    } hit_word_t;

    // Merged output stream word
    typedef logic [31:0] data_word_t;

endpackage

`default_nettype wire

// ==== include/daq_consts.svh ====
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// Bus widths
`define DAQ_ABUS_W 16
`define DAQ_DBUS_W 8

// Address windows, 0x100 bytes each
`define DAQ_WIN_MASK   16'hFF00
`define DAQ_SYS_BASE   16'h0300
`define DAQ_PULSE_BASE 16'h0400
`define DAQ_CTRL_BASE  16'h0500

// System window offsets
`define DAQ_SYS_VERSION 8'd0
`define DAQ_SYS_MINOR   8'd1
`define DAQ_SYS_MAJOR   8'd2
`define DAQ_SYS_BOARD   8'd3
`define DAQ_SYS_FLAG_RD 8'd4
`define DAQ_SYS_FLAG_WR 8'd5

// Pulser window offsets
`define DAQ_PULSE_START 8'd0
`define DAQ_PULSE_DELAY 8'd1
`define DAQ_PULSE_WIDTH 8'd2
`define DAQ_PULSE_DONE  8'd3

// Control window offsets
`define DAQ_CTRL_LO 8'd0
`define DAQ_CTRL_HI 8'd1

// Readback constants
`define DAQ_VERSION  8'd1
`define DAQ_FW_MINOR 8'd0
`define DAQ_FW_MAJOR 8'd1
`define DAQ_BOARD_ID 8'd0

`define DAQ_HIT_ID      3'd2
`define DAQ_FIFO_DEPTH  8
`define DAQ_SYNC_STAGES 3

`endif
